// ==== hw/shoot_pkg.sv ====
package shoot_pkg;

    // bus widths
    localparam int POS_W    = 12;   // cursor coordinates
    localparam int PIX_W    = 11;   // vga counters
    localparam int RGB_W    = 12;
    localparam int KEEPER_W = 10;
    localparam int SHOT_W   = 10;   // coordinate bits sent to the other board

    // round phase, shared by the fsm and the overlay
    typedef enum logic [2:0] {
        IDLE,
        ENGAGE,
        AIM,
        RESULT,
        GOAL,
        MISS,
        TERMINATE
    } shoot_state_t;

    typedef enum logic {
        SOLO,
        MULTI
    } game_mode_t;

    // tag in the low 3 bits of every position byte
    typedef enum logic [2:0] {
        OP_X_LO = 3'd3,
        OP_X_HI = 3'd4,
        OP_Y_LO = 3'd5,
        OP_Y_HI = 3'd6
    } tx_opcode_t;

    // goal mouth
    localparam int POST_INNER_EDGE  = 160;
    localparam int SCREEN_WIDTH     = 1024;
    localparam int CROSSBAR_EDGE    = 150;
    localparam int POST_BOTTOM_EDGE = 600;

    // keeper box
    localparam int GK_TOP_Y      = 250;
    localparam int GK_BOTTOM_Y   = 550;
    localparam int GK_WIDTH      = 200;
    localparam int GK_HALF_WIDTH = 100;
    localparam int GK_SOLO_LEFT  = 400;
    localparam int KEEPER_MIN    = 255;   // keeps the box on screen
    localparam int KEEPER_MAX    = 769;

    localparam logic [RGB_W-1:0] COLOR_AIM  = 12'h00F;
    localparam logic [RGB_W-1:0] COLOR_GOAL = 12'h0F0;
    localparam logic [RGB_W-1:0] COLOR_MISS = 12'hF00;

endpackage

// ==== hw/round_fsm.sv ====
`timescale 1ns/1ps

module round_fsm #(
    parameter logic [25:0] HOLD_CYCLES  = 26'd16_250_000,
    parameter int          ENEMY_SETTLE = 10
) (
    input  logic                    clk,
    input  logic                    rst,
    input  shoot_pkg::game_mode_t   mode,
    input  logic                    shooter_turn,
    input  logic                    left_clicked,
    input  logic                    enemy_done,
    input  logic                    enemy_scored,
    input  logic                    goal_hit,
    output shoot_pkg::shoot_state_t phase,
    output logic                    take_shot,
    output logic                    send_req,
    output logic                    is_scored,
    output logic                    round_done,
    output logic                    shot_taken,
    output logic                    end_sh
);
    import shoot_pkg::*;

    shoot_state_t phase_nxt;
    logic [25:0]  count;
    logic [25:0]  count_nxt;

    // click strobe, same cycle as the click
    assign take_shot = (phase == AIM) && left_clicked;
    assign send_req  = take_shot && (mode == MULTI);

    always_comb begin
        phase_nxt = phase;
        count_nxt = '0;     // cleared on every phase change

        case (phase)
            IDLE: begin
                if (shooter_turn) begin
                    phase_nxt = ENGAGE;
                end
            end
            ENGAGE: begin
                phase_nxt = shooter_turn ? AIM : IDLE;
            end
            AIM: begin
                if (left_clicked) begin
                    phase_nxt = RESULT;
                end
            end
            RESULT: begin
                if (mode == SOLO) begin
                    phase_nxt = goal_hit ? GOAL : MISS;   // local verdict is ready
                end else if (enemy_done) begin
                    // enemy flag must be steady before it is trusted
                    if (count == 26'(ENEMY_SETTLE)) begin
                        phase_nxt = enemy_scored ? GOAL : MISS;
                    end else begin
                        count_nxt = count + 26'd1;
                    end
                end
            end
            GOAL, MISS: begin
                if (count == HOLD_CYCLES) begin
                    phase_nxt = TERMINATE;
                end else begin
                    count_nxt = count + 26'd1;
                end
            end
            TERMINATE: begin
                // multi waits once more so the other board can catch up
                if ((mode == SOLO) || (count == HOLD_CYCLES)) begin
                    phase_nxt = IDLE;
                end else begin
                    count_nxt = count + 26'd1;
                end
            end
            default: begin
                phase_nxt = IDLE;
            end
        endcase
    end

    // status flags follow the registered phase cycle for cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            phase      <= IDLE;
            count      <= '0;
            is_scored  <= 1'b0;
            round_done <= 1'b0;
            shot_taken <= 1'b0;
            end_sh     <= 1'b0;
        end else begin
            phase      <= phase_nxt;
            count      <= count_nxt;
            is_scored  <= (mode == SOLO) && (phase_nxt == GOAL);
            shot_taken <= (mode == MULTI) && (phase_nxt == RESULT);
            round_done <= (mode == SOLO) && (phase_nxt inside {GOAL, MISS})
                          && (count_nxt == HOLD_CYCLES);   // last hold cycle
            end_sh     <= (phase == TERMINATE) && (phase_nxt == IDLE);
        end
    end

endmodule

// ==== hw/shot_judge.sv ====
`timescale 1ns/1ps

module shot_judge (
    input  logic                            clk,
    input  logic                            rst,
    input  shoot_pkg::game_mode_t           mode,
    input  logic                            take_shot,
    input  logic [shoot_pkg::POS_W-1:0]     xpos,
    input  logic [shoot_pkg::POS_W-1:0]     ypos,
    input  logic [shoot_pkg::KEEPER_W-1:0]  keeper_pos,
    output logic [shoot_pkg::KEEPER_W-1:0]  keeper_left,
    output logic [shoot_pkg::SHOT_W-1:0]    shot_x,
    output logic [shoot_pkg::SHOT_W-1:0]    shot_y,
    output logic                            goal_hit
);
    import shoot_pkg::*;

    logic [KEEPER_W-1:0] keeper_clamped;
    logic [KEEPER_W-1:0] keeper_place;
    logic [POS_W-1:0]    box_left;
    logic [POS_W-1:0]    box_right;
    logic                in_mouth;
    logic                in_box;

    always_comb begin
        if (keeper_pos < KEEPER_W'(KEEPER_MIN)) begin
            keeper_clamped = KEEPER_W'(KEEPER_MIN);
        end else if (keeper_pos > KEEPER_W'(KEEPER_MAX)) begin
            keeper_clamped = KEEPER_W'(KEEPER_MAX);
        end else begin
            keeper_clamped = keeper_pos;
        end
    end

    // keeper_pos is the box centre, the box is drawn from its left edge
    assign keeper_place = (mode == SOLO) ? KEEPER_W'(GK_SOLO_LEFT)
                                         : keeper_clamped - KEEPER_W'(GK_HALF_WIDTH);

    assign box_left  = POS_W'(keeper_place);
    assign box_right = box_left + POS_W'(GK_WIDTH);

    // bounds inclusive
    assign in_mouth = (xpos >= POS_W'(POST_INNER_EDGE))
                   && (xpos <= POS_W'(SCREEN_WIDTH - POST_INNER_EDGE))
                   && (ypos >= POS_W'(CROSSBAR_EDGE))
                   && (ypos <= POS_W'(POST_BOTTOM_EDGE));

    assign in_box = (xpos >= box_left) && (xpos <= box_right)
                 && (ypos >= POS_W'(GK_TOP_Y)) && (ypos <= POS_W'(GK_BOTTOM_Y));

    always_ff @(posedge clk) begin
        if (rst) begin
            keeper_left <= '0;
            shot_x      <= '0;
            shot_y      <= '0;
            goal_hit    <= 1'b0;
        end else begin
            keeper_left <= keeper_place;   // follows the keeper every cycle
            if (take_shot) begin
                shot_x   <= xpos[SHOT_W-1:0];
                shot_y   <= ypos[SHOT_W-1:0];
                goal_hit <= in_mouth && !in_box;
            end
        end
    end

endmodule

// ==== hw/keeper_overlay.sv ====
`timescale 1ns/1ps

module keeper_overlay (
    input  logic                            clk,
    input  logic                            rst,
    input  shoot_pkg::shoot_state_t         phase,
    input  logic [shoot_pkg::KEEPER_W-1:0]  keeper_left,
    input  logic [shoot_pkg::PIX_W-1:0]     hcount,
    input  logic [shoot_pkg::PIX_W-1:0]     vcount,
    input  logic [shoot_pkg::RGB_W-1:0]     rgb,
    output logic [shoot_pkg::PIX_W-1:0]     hcount_out,
    output logic [shoot_pkg::PIX_W-1:0]     vcount_out,
    output logic [shoot_pkg::RGB_W-1:0]     rgb_out
);
    import shoot_pkg::*;

    logic [PIX_W-1:0] box_left;
    logic [PIX_W-1:0] box_right;
    logic             in_box;
    logic [RGB_W-1:0] rgb_nxt;

    assign box_left  = PIX_W'(keeper_left);
    assign box_right = box_left + PIX_W'(GK_WIDTH);

    assign in_box = (hcount >= box_left) && (hcount <= box_right)
                 && (vcount >= PIX_W'(GK_TOP_Y)) && (vcount <= PIX_W'(GK_BOTTOM_Y));

    always_comb begin
        rgb_nxt = rgb;
        if (in_box) begin
            case (phase)
                AIM, RESULT: rgb_nxt = COLOR_AIM;
                GOAL:        rgb_nxt = COLOR_GOAL;
                MISS:        rgb_nxt = COLOR_MISS;
                default:     rgb_nxt = rgb;       // keeper hidden between rounds
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount_out <= '0;
            vcount_out <= '0;
            rgb_out    <= '0;
        end else begin
            hcount_out <= hcount;
            vcount_out <= vcount;
            rgb_out    <= rgb_nxt;
        end
    end

endmodule

// ==== hw/shot_tx.sv ====
`timescale 1ns/1ps

module shot_tx (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          send_req,
    input  logic [shoot_pkg::SHOT_W-1:0]  shot_x,
    input  logic [shoot_pkg::SHOT_W-1:0]  shot_y,
    input  logic                          tx_ready,
    output logic [7:0]                    tx_data,
    output logic                          tx_valid
);
    import shoot_pkg::*;

    tx_opcode_t        op;
    logic [SHOT_W-1:0] x_q;
    logic [SHOT_W-1:0] y_q;
    logic [SHOT_W-1:0] x_src;
    logic [SHOT_W-1:0] y_src;
    logic              load;     // first byte cycle, shot latch just settled
    logic [4:0]        field;

    // the judge latches the shot on the same edge as the request
    assign x_src = load ? shot_x : x_q;
    assign y_src = load ? shot_y : y_q;

    always_comb begin
        case (op)
            OP_X_LO: field = x_src[4:0];
            OP_X_HI: field = x_src[9:5];
            OP_Y_LO: field = y_src[4:0];
            default: field = y_src[9:5];
        endcase
    end

    // op and coordinates only move on a handshake, so data holds under stall
    assign tx_data = tx_valid ? {field, op} : 8'h00;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_valid <= 1'b0;
            op       <= OP_X_LO;
        end else if (!tx_valid) begin
            if (send_req) begin
                tx_valid <= 1'b1;
                op       <= OP_X_LO;
            end
        end else if (tx_ready) begin
            case (op)
                OP_X_LO: op <= OP_X_HI;
                OP_X_HI: op <= OP_Y_LO;
                OP_Y_LO: op <= OP_Y_HI;
                default: begin
                    tx_valid <= 1'b0;   // fourth byte taken
                    op       <= OP_X_LO;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            load <= 1'b0;
        end else begin
            load <= send_req && !tx_valid;
        end
    end

    // coordinates held for the rest of the burst
    always_ff @(posedge clk) begin
        if (load) begin
            x_q <= shot_x;
            y_q <= shot_y;
        end
    end

endmodule

// ==== hw/shoot_control.sv ====
`timescale 1ns/1ps

module shoot_control #(
    parameter logic [25:0] HOLD_CYCLES  = 26'd16_250_000,
    parameter int          ENEMY_SETTLE = 10
) (
    input  logic                            clk,
    input  logic                            rst,
    input  shoot_pkg::game_mode_t           mode,
    input  logic                            shooter_turn,
    input  logic [shoot_pkg::POS_W-1:0]     xpos,
    input  logic [shoot_pkg::POS_W-1:0]     ypos,
    input  logic [shoot_pkg::KEEPER_W-1:0]  keeper_pos,
    input  logic                            left_clicked,
    input  logic                            enemy_done,    // opponent finished judging
    input  logic                            enemy_scored,
    input  logic [shoot_pkg::PIX_W-1:0]     hcount,
    input  logic [shoot_pkg::PIX_W-1:0]     vcount,
    input  logic [shoot_pkg::RGB_W-1:0]     rgb,
    input  logic                            tx_ready,
    output logic                            is_scored,
    output logic                            round_done,
    output logic                            end_sh,
    output logic                            shot_taken,
    output logic [7:0]                      tx_data,
    output logic                            tx_valid,
    output logic [shoot_pkg::PIX_W-1:0]     hcount_out,
    output logic [shoot_pkg::PIX_W-1:0]     vcount_out,
    output logic [shoot_pkg::RGB_W-1:0]     rgb_out
);
    import shoot_pkg::*;

    shoot_state_t        phase;
    logic                take_shot;
    logic                send_req;
    logic                goal_hit;
    logic [KEEPER_W-1:0] keeper_left;
    logic [SHOT_W-1:0]   shot_x;
    logic [SHOT_W-1:0]   shot_y;

    round_fsm #(
        .HOLD_CYCLES  (HOLD_CYCLES),
        .ENEMY_SETTLE (ENEMY_SETTLE)
    ) u_round_fsm (
        .clk          (clk),
        .rst          (rst),
        .mode         (mode),
        .shooter_turn (shooter_turn),
        .left_clicked (left_clicked),
        .enemy_done   (enemy_done),
        .enemy_scored (enemy_scored),
        .goal_hit     (goal_hit),
        .phase        (phase),
        .take_shot    (take_shot),
        .send_req     (send_req),
        .is_scored    (is_scored),
        .round_done   (round_done),
        .shot_taken   (shot_taken),
        .end_sh       (end_sh)
    );

    shot_judge u_shot_judge (
        .clk         (clk),
        .rst         (rst),
        .mode        (mode),
        .take_shot   (take_shot),
        .xpos        (xpos),
        .ypos        (ypos),
        .keeper_pos  (keeper_pos),
        .keeper_left (keeper_left),
        .shot_x      (shot_x),
        .shot_y      (shot_y),
        .goal_hit    (goal_hit)
    );

    keeper_overlay u_keeper_overlay (
        .clk         (clk),
        .rst         (rst),
        .phase       (phase),
        .keeper_left (keeper_left),
        .hcount      (hcount),
        .vcount      (vcount),
        .rgb         (rgb),
        .hcount_out  (hcount_out),
        .vcount_out  (vcount_out),
        .rgb_out     (rgb_out)
    );

    // position report, multi mode only
    shot_tx u_shot_tx (
        .clk      (clk),
        .rst      (rst),
        .send_req (send_req),
        .shot_x   (shot_x),
        .shot_y   (shot_y),
        .tx_ready (tx_ready),
        .tx_data  (tx_data),
        .tx_valid (tx_valid)
    );

endmodule

// ==== verif/tb_shoot_control.sv ====
`timescale 1ns/1ps

module tb_shoot_control;
    import shoot_pkg::*;

    localparam logic [25:0] HOLD   = 26'd20;
    localparam int          SETTLE = 10;
    localparam int          HOLD_N = int'(HOLD) + 1;   // cycles in each hold phase
    localparam int          TMO    = 500;

    logic                clk;
    logic                rst;
    game_mode_t          mode;
    logic                shooter_turn;
    logic [POS_W-1:0]    xpos;
    logic [POS_W-1:0]    ypos;
    logic [KEEPER_W-1:0] keeper_pos;
    logic                left_clicked;
    logic                enemy_done;
    logic                enemy_scored;
    logic [PIX_W-1:0]    hcount;
    logic [PIX_W-1:0]    vcount;
    logic [RGB_W-1:0]    rgb;
    logic                tx_ready;
    logic                is_scored;
    logic                round_done;
    logic                end_sh;
    logic                shot_taken;
    logic [7:0]          tx_data;
    logic                tx_valid;
    logic [PIX_W-1:0]    hcount_out;
    logic [PIX_W-1:0]    vcount_out;
    logic [RGB_W-1:0]    rgb_out;

    integer              seed;
    logic [31:0]         rnd;        // pixel and ready driver only
    logic [31:0]         pick;       // cursor points
    logic [POS_W-1:0]    goal_x;
    logic [POS_W-1:0]    goal_y;
    logic [POS_W-1:0]    wide_x;
    logic [POS_W-1:0]    wide_y;
    logic [POS_W-1:0]    box_x;
    logic [POS_W-1:0]    box_y;

    // expected outputs for the cycle that follows the current edge
    logic                exp_scored;
    logic                exp_done;
    logic                exp_end;
    logic                exp_taken;
    logic [PIX_W-1:0]    exp_h;
    logic [PIX_W-1:0]    exp_v;
    logic [RGB_W-1:0]    exp_rgb;
    logic [7:0]          exp_byte [4];
    logic [2:0]          sent_cnt;
    logic [2:0]          sent_max;

    logic                paint_on;   // keeper box visible this cycle
    logic [RGB_W-1:0]    paint_col;
    logic                pix_in;     // driven pixel lies in the keeper box
    logic                pix_run;
    int                  box_left_exp;

    shoot_control #(
        .HOLD_CYCLES  (HOLD),
        .ENEMY_SETTLE (SETTLE)
    ) u_shoot_control (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_mismatch(input string msg);
        $display("FAILED at time %0t: %s", $time, msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic report_timeout(input string what);
        $display("timed out at time %0t waiting for %s", $time, what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // overlay and byte counter model
    always @(posedge clk) begin
        if (rst) begin
            exp_h    <= '0;
            exp_v    <= '0;
            exp_rgb  <= '0;
            sent_cnt <= '0;
        end else begin
            exp_h   <= hcount;
            exp_v   <= vcount;
            exp_rgb <= (pix_in && paint_on) ? paint_col : rgb;
            if (tx_valid && tx_ready) begin
                sent_cnt <= sent_cnt + 3'd1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) is_scored == exp_scored)
        else report_mismatch("is_scored does not follow the solo goal hold");
    assert property (@(posedge clk) disable iff (rst) round_done == exp_done)
        else report_mismatch("round_done pulse is wrong");
    assert property (@(posedge clk) disable iff (rst) end_sh == exp_end)
        else report_mismatch("end_sh pulse is wrong");
    assert property (@(posedge clk) disable iff (rst) shot_taken == exp_taken)
        else report_mismatch("shot_taken does not cover the multi result wait");
    assert property (@(posedge clk) disable iff (rst) rgb_out == exp_rgb)
        else report_mismatch("rgb_out differs from the painted pixel");
    assert property (@(posedge clk) disable iff (rst)
                     (hcount_out == exp_h) && (vcount_out == exp_v))
        else report_mismatch("pixel counters not delayed by one cycle");
    assert property (@(posedge clk) disable iff (rst)
                     $past(tx_valid && !tx_ready) |-> (tx_valid && (tx_data == $past(tx_data))))
        else report_mismatch("tx byte changed while stalled");
    assert property (@(posedge clk) disable iff (rst)
                     (tx_valid && tx_ready) |->
                     ((sent_cnt < sent_max) && (tx_data == exp_byte[sent_cnt[1:0]])))
        else report_mismatch("unexpected or wrong position byte");

    // free running pixel stream and random back-pressure
    initial begin
        hcount   = '0;
        vcount   = '0;
        rgb      = '0;
        tx_ready = 1'b0;
        pix_in   = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            if (pix_run) begin
                rnd      = $random(seed);
                tx_ready = rnd[0];
                rgb      = rnd[RGB_W:1];
                pix_in   = !pix_in;
                rnd      = $random(seed);
                if (pix_in) begin
                    hcount = PIX_W'(box_left_exp) + PIX_W'(rnd[7:0] % 201);
                    vcount = PIX_W'(GK_TOP_Y) + PIX_W'(rnd[16:8] % 301);
                end else begin
                    hcount = PIX_W'(rnd[9:0]);
                    vcount = PIX_W'(GK_BOTTOM_Y + 1) + PIX_W'(rnd[16:10]);   // below the box
                end
            end
        end
    end

    task automatic play_round(input logic [POS_W-1:0] x, input logic [POS_W-1:0] y,
                              input logic scored);
        int run;
        int i;
        shooter_turn = 1'b1;
        xpos         = x;
        ypos         = y;
        next_cycle();                  // engage
        next_cycle();                  // aim
        paint_on  = 1'b1;
        paint_col = COLOR_AIM;
        if (mode == MULTI) begin
            exp_byte[0] = {x[4:0], OP_X_LO};
            exp_byte[1] = {x[9:5], OP_X_HI};
            exp_byte[2] = {y[4:0], OP_Y_LO};
            exp_byte[3] = {y[9:5], OP_Y_HI};
            sent_max    = sent_max + 3'd4;
        end
        repeat (3) next_cycle();
        left_clicked = 1'b1;
        next_cycle();                  // result
        left_clicked = 1'b0;
        shooter_turn = 1'b0;
        if (mode == SOLO) begin
            next_cycle();
        end else begin
            exp_taken = 1'b1;
            run       = 0;
            i         = 0;
            while (run < SETTLE + 1) begin
                enemy_done   = (i != 3);   // early dropout restarts the count
                enemy_scored = scored;
                next_cycle();
                run = enemy_done ? run + 1 : 0;
                i++;
            end
            exp_taken  = 1'b0;
            enemy_done = 1'b0;
        end
        paint_col = scored ? COLOR_GOAL : COLOR_MISS;
        for (i = 0; i < HOLD_N; i++) begin
            exp_scored = scored && (mode == SOLO);
            exp_done   = (mode == SOLO) && (i == HOLD_N - 1);
            next_cycle();
        end
        exp_scored = 1'b0;
        exp_done   = 1'b0;
        paint_on   = 1'b0;
        if (mode == MULTI) begin
            repeat (HOLD_N) next_cycle();   // terminate holds as long again
        end else begin
            next_cycle();
        end
        exp_end = 1'b1;
        next_cycle();
        exp_end = 1'b0;
    endtask

    task automatic wait_tx_drain();
        int cycles;
        cycles = 0;
        while (tx_valid || (sent_cnt != sent_max)) begin
            next_cycle();
            cycles++;
            if (cycles > TMO) begin
                report_timeout("the four position bytes");
            end
        end
    endtask

    initial begin
        seed         = 32'h08ca_e75a;
        rst          = 1'b1;
        mode         = SOLO;
        shooter_turn = 1'b0;
        xpos         = '0;
        ypos         = '0;
        keeper_pos   = 10'd900;       // clamps to KEEPER_MAX in multi
        left_clicked = 1'b0;
        enemy_done   = 1'b0;
        enemy_scored = 1'b0;
        exp_scored   = 1'b0;
        exp_done     = 1'b0;
        exp_end      = 1'b0;
        exp_taken    = 1'b0;
        sent_max     = '0;
        paint_on     = 1'b0;
        paint_col    = '0;
        pix_run      = 1'b0;
        box_left_exp = GK_SOLO_LEFT;
        for (int k = 0; k < 4; k++) begin
            exp_byte[k] = '0;
        end

        pick   = $random(seed);
        goal_x = POS_W'(POST_INNER_EDGE + pick[7:0] % 240);   // left of the keeper
        goal_y = POS_W'(CROSSBAR_EDGE + pick[16:8] % 451);
        pick   = $random(seed);
        wide_x = POS_W'(SCREEN_WIDTH - POST_INNER_EDGE + 1 + pick[7:0] % 100);
        wide_y = POS_W'(GK_TOP_Y + pick[16:8] % 301);
        pick   = $random(seed);
        box_x  = POS_W'(GK_SOLO_LEFT + pick[7:0] % 201);
        box_y  = POS_W'(GK_TOP_Y + pick[16:8] % 301);

        repeat (10) @(posedge clk);
        #2;
        rst     = 1'b0;
        pix_run = 1'b1;
        repeat (2) next_cycle();

        play_round(goal_x, goal_y, 1'b1);
        play_round(wide_x, wide_y, 1'b0);
        play_round(box_x, box_y, 1'b0);

        mode         = MULTI;
        box_left_exp = KEEPER_MAX - GK_HALF_WIDTH;
        repeat (3) next_cycle();
        play_round(goal_x, goal_y, 1'b1);   // aim point differs from the last shot
        wait_tx_drain();
        repeat (4) next_cycle();

        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== src.f ====
hw/shoot_pkg.sv
hw/round_fsm.sv
hw/shot_judge.sv
hw/keeper_overlay.sv
hw/shot_tx.sv
hw/shoot_control.sv
verif/tb_shoot_control.sv

// ==== run.sh ====
#!/bin/sh
# build with verilator, run, and look for the pass line in the output
verilator --binary --timing --assert --top-module tb_shoot_control -f src.f -o sim_shoot \
    && ./obj_dir/sim_shoot | tee /dev/stderr | grep -qx "Testbench passed" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
